// ==== include/mipsCfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Datapath and register file sizes
`define MIPS_WORD_WIDTH     32
`define MIPS_REG_ADDR_WIDTH 5
`define MIPS_NUM_REGS       32
`define MIPS_SHAMT_WIDTH    5

// Main opcodes, instr[31:26]
`define MIPS_OP_RTYPE 6'b000000
`define MIPS_OP_LW    6'b100011
`define MIPS_OP_SW    6'b101011
`define MIPS_OP_BEQ   6'b000100
`define MIPS_OP_ADDI  6'b001000
`define MIPS_OP_J     6'b000010
`define MIPS_OP_LUI   6'b001111

// R-type funct codes, instr[5:0]
`define MIPS_FN_ADD 6'b100000
`define MIPS_FN_SUB 6'b100010
`define MIPS_FN_AND 6'b100100
`define MIPS_FN_OR  6'b100101
`define MIPS_FN_NOR 6'b100111
`define MIPS_FN_XOR 6'b100110
`define MIPS_FN_SLT 6'b101010
`define MIPS_FN_SLL 6'b000000
`define MIPS_FN_SRL 6'b000010
`define MIPS_FN_SRA 6'b000011

`endif

// ==== logic/mipsPkg.sv ====
`default_nettype none

`include "mipsCfg.svh"

package mipsPkg;

	//------------------------------------------------------------
	// Instruction word, one word seen in three formats
	//------------------------------------------------------------
	typedef union packed {
		struct packed {
			logic [5:0]                      opcode;
			logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
			logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
			logic [`MIPS_REG_ADDR_WIDTH-1:0] rd;
			logic [`MIPS_SHAMT_WIDTH-1:0]    shamt;
			logic [5:0]                      funct;
		} rType;
		struct packed {
			logic [5:0]                      opcode;
			logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
			logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
			logic [15:0]                     imm16;
		} iType;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] target26;
		} jType;
	} instrWord_t;

	// Bit 2 set means operand B is inverted for the adder
	typedef enum logic [2:0] {
		ALU_AND = 3'b000,
		ALU_OR  = 3'b001,
		ALU_ADD = 3'b010,
		ALU_LUI = 3'b011,
		ALU_NOR = 3'b100,
		ALU_XOR = 3'b101,
		ALU_SUB = 3'b110,
		ALU_SLT = 3'b111
	} aluOp_t;

	typedef enum logic [1:0] {
		SHIFT_SLL = 2'b00,
		SHIFT_SRL = 2'b01,
		SHIFT_SRA = 2'b10
	} shiftOp_t;

	//------------------------------------------------------------
	// Control and pipeline payloads
	//------------------------------------------------------------
	typedef struct packed {
		logic     regWrite;
		logic     regDst;   // 1 selects rd, 0 selects rt
		logic     aluSrc;   // 1 selects the immediate
		logic     branch;
		logic     memWrite;
		logic     memToReg;
		logic     jump;
		aluOp_t   aluOp;
		logic     useShift; // Shifter result instead of ALU
		shiftOp_t shiftOp;
	} ctrlSig_t;

	typedef struct packed {
		ctrlSig_t                        ctrl;
		logic [`MIPS_WORD_WIDTH-1:0]     srcA;
		logic [`MIPS_WORD_WIDTH-1:0]     regB;
		logic [`MIPS_WORD_WIDTH-1:0]     signImm;
		logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
		logic [`MIPS_REG_ADDR_WIDTH-1:0] rd;
		logic [`MIPS_SHAMT_WIDTH-1:0]    shamt;
	} decExec_t;

	typedef struct packed {
		logic                            regWrite;
		logic                            memWrite;
		logic                            memToReg;
		logic [`MIPS_WORD_WIDTH-1:0]     execOut;
		logic [`MIPS_WORD_WIDTH-1:0]     writeData;
		logic [`MIPS_REG_ADDR_WIDTH-1:0] writeReg;
	} execMem_t;

endpackage

`default_nettype wire

// ==== logic/controlDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCfg.svh"

module controlDecoder (
	input  wire logic [5:0]       opcode,
	input  wire logic [5:0]       funct,
	output mipsPkg::ctrlSig_t     ctrl
);

	always_comb begin
		ctrl = '0; // Unknown codes fall through as a no-op
		case (opcode)
			`MIPS_OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				case (funct)
					`MIPS_FN_ADD: ctrl.aluOp = mipsPkg::ALU_ADD;
					`MIPS_FN_SUB: ctrl.aluOp = mipsPkg::ALU_SUB;
					`MIPS_FN_AND: ctrl.aluOp = mipsPkg::ALU_AND;
					`MIPS_FN_OR:  ctrl.aluOp = mipsPkg::ALU_OR;
					`MIPS_FN_NOR: ctrl.aluOp = mipsPkg::ALU_NOR;
					`MIPS_FN_XOR: ctrl.aluOp = mipsPkg::ALU_XOR;
					`MIPS_FN_SLT: ctrl.aluOp = mipsPkg::ALU_SLT;
					`MIPS_FN_SLL: begin
						ctrl.useShift = 1'b1;
						ctrl.shiftOp = mipsPkg::SHIFT_SLL;
					end
					`MIPS_FN_SRL: begin
						ctrl.useShift = 1'b1;
						ctrl.shiftOp = mipsPkg::SHIFT_SRL;
					end
					`MIPS_FN_SRA: begin
						ctrl.useShift = 1'b1;
						ctrl.shiftOp = mipsPkg::SHIFT_SRA;
					end
					default: ctrl = '0;
				endcase
			end
			`MIPS_OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_ADD; // Base plus offset
			end
			`MIPS_OP_SW: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_ADD;
			end
			`MIPS_OP_BEQ: ctrl.branch = 1'b1; // Resolved in decode
			`MIPS_OP_ADDI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_ADD;
			end
			`MIPS_OP_J: ctrl.jump = 1'b1;
			`MIPS_OP_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_LUI;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/fetchStage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCfg.svh"

module fetchStage (
	input  wire logic                         clk,
	input  wire logic                         reset,
	input  wire logic                         branchTaken,
	input  wire logic                         jumpTaken,
	input  wire logic [`MIPS_WORD_WIDTH-1:0]  branchTarget,
	input  wire logic [`MIPS_WORD_WIDTH-1:0]  jumpTarget,
	input  wire mipsPkg::instrWord_t          instr,
	output logic [`MIPS_WORD_WIDTH-1:0]       pc,
	output mipsPkg::instrWord_t               instrD,
	output logic [`MIPS_WORD_WIDTH-1:0]       pcPlus4D
);

	logic [`MIPS_WORD_WIDTH-1:0] pcPlus4;
	logic [`MIPS_WORD_WIDTH-1:0] pcNext;

	assign pcPlus4 = pc + `MIPS_WORD_WIDTH'd4;

	// Jump wins over branch, both come from the decode stage
	assign pcNext = jumpTaken ? jumpTarget :
		branchTaken ? branchTarget : pcPlus4;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
			instrD <= '0; // All-zero word is SLL r0, a no-op
			pcPlus4D <= '0;
		end else begin
			pc <= pcNext;
			instrD <= instr;
			pcPlus4D <= pcPlus4;
		end
	end

endmodule

`default_nettype wire

// ==== logic/decodeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCfg.svh"

module decodeStage (
	input  wire logic                            clk,
	input  wire logic                            reset,
	input  wire mipsPkg::instrWord_t             instrD,
	input  wire logic [`MIPS_WORD_WIDTH-1:0]     pcPlus4D,
	input  wire mipsPkg::ctrlSig_t               ctrl,
	input  wire logic                            wbRegWrite,
	input  wire logic [`MIPS_REG_ADDR_WIDTH-1:0] wbReg,
	input  wire logic [`MIPS_WORD_WIDTH-1:0]     wbResult,
	input  wire logic [`MIPS_REG_ADDR_WIDTH-1:0] dispSel,
	output logic [`MIPS_WORD_WIDTH-1:0]          dispData,
	output logic                                 branchTaken,
	output logic [`MIPS_WORD_WIDTH-1:0]          branchTarget,
	output logic [`MIPS_WORD_WIDTH-1:0]          jumpTarget,
	output logic                                 jumpTaken,
	output mipsPkg::decExec_t                    decExec
);

	logic [`MIPS_WORD_WIDTH-1:0] regFile [0:`MIPS_NUM_REGS-1];
	logic [`MIPS_WORD_WIDTH-1:0] rdA;
	logic [`MIPS_WORD_WIDTH-1:0] rdB;
	logic [`MIPS_WORD_WIDTH-1:0] signImm;
	mipsPkg::decExec_t           decExecNext;

	//------------------------------------------------------------
	// Register file, one write port and three read ports
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wbRegWrite)
			regFile[wbReg] <= wbResult;
	end

	// Register 0 is hardwired on every read port
	assign rdA = (instrD.rType.rs != '0) ? regFile[instrD.rType.rs] : '0;
	assign rdB = (instrD.rType.rt != '0) ? regFile[instrD.rType.rt] : '0;
	assign dispData = (dispSel != '0) ? regFile[dispSel] : '0; // Debug view

	//------------------------------------------------------------
	// Immediate and control-flow targets
	//------------------------------------------------------------
	assign signImm = {{(`MIPS_WORD_WIDTH-16){instrD.iType.imm16[15]}}, instrD.iType.imm16};

	assign branchTaken = ctrl.branch && (rdA == rdB);
	assign branchTarget = pcPlus4D + {signImm[`MIPS_WORD_WIDTH-3:0], 2'b00};
	assign jumpTaken = ctrl.jump;
	assign jumpTarget = {pcPlus4D[`MIPS_WORD_WIDTH-1:28], instrD.jType.target26, 2'b00};

	always_comb begin
		decExecNext.ctrl = ctrl;
		decExecNext.srcA = rdA;
		decExecNext.regB = rdB;
		decExecNext.signImm = signImm;
		decExecNext.rt = instrD.rType.rt;
		decExecNext.rd = instrD.rType.rd;
		decExecNext.shamt = instrD.rType.shamt;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			decExec <= '0; // Empty control, nothing written
		else
			decExec <= decExecNext;
	end

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCfg.svh"

module executeStage (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire mipsPkg::decExec_t   decExec,
	output mipsPkg::execMem_t        execMem
);

	logic [`MIPS_WORD_WIDTH-1:0] srcB;
	logic [`MIPS_WORD_WIDTH-1:0] srcBAdd;
	logic [`MIPS_WORD_WIDTH-1:0] sum;
	logic [`MIPS_WORD_WIDTH-1:0] aluOut;
	logic [`MIPS_WORD_WIDTH-1:0] shiftOut;
	mipsPkg::execMem_t           execMemNext;

	assign srcB = decExec.ctrl.aluSrc ? decExec.signImm : decExec.regB;

	//------------------------------------------------------------
	// ALU
	//------------------------------------------------------------
	assign srcBAdd = decExec.ctrl.aluOp[2] ? ~srcB : srcB; // Subtract via invert plus one
	assign sum = decExec.srcA + srcBAdd + {{(`MIPS_WORD_WIDTH-1){1'b0}}, decExec.ctrl.aluOp[2]};

	always_comb begin
		case (decExec.ctrl.aluOp)
			mipsPkg::ALU_AND: aluOut = decExec.srcA & srcB;
			mipsPkg::ALU_OR:  aluOut = decExec.srcA | srcB;
			mipsPkg::ALU_ADD: aluOut = sum;
			mipsPkg::ALU_LUI: aluOut = {srcB[15:0], 16'h0000};
			mipsPkg::ALU_NOR: aluOut = ~(decExec.srcA | srcB);
			mipsPkg::ALU_XOR: aluOut = decExec.srcA ^ srcB;
			mipsPkg::ALU_SUB: aluOut = sum;
			mipsPkg::ALU_SLT: aluOut = {{(`MIPS_WORD_WIDTH-1){1'b0}},
				$signed(decExec.srcA) < $signed(srcB)};
			default:          aluOut = '0;
		endcase
	end

	// Immediate shifts only, amount comes from the shamt field
	always_comb begin
		case (decExec.ctrl.shiftOp)
			mipsPkg::SHIFT_SLL: shiftOut = decExec.regB << decExec.shamt;
			mipsPkg::SHIFT_SRL: shiftOut = decExec.regB >> decExec.shamt;
			mipsPkg::SHIFT_SRA: shiftOut = $signed(decExec.regB) >>> decExec.shamt;
			default:            shiftOut = '0;
		endcase
	end

	always_comb begin
		execMemNext.regWrite = decExec.ctrl.regWrite;
		execMemNext.memWrite = decExec.ctrl.memWrite;
		execMemNext.memToReg = decExec.ctrl.memToReg;
		execMemNext.execOut = decExec.ctrl.useShift ? shiftOut : aluOut;
		execMemNext.writeData = decExec.regB; // Store data for SW
		execMemNext.writeReg = decExec.ctrl.regDst ? decExec.rd : decExec.rt;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			execMem <= '0;
		else
			execMem <= execMemNext;
	end

endmodule

`default_nettype wire

// ==== logic/writebackStage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCfg.svh"

module writebackStage (
	input  wire logic                            clk,
	input  wire logic                            reset,
	input  wire mipsPkg::execMem_t               execMem,
	input  wire logic [`MIPS_WORD_WIDTH-1:0]     memReadData,
	output logic                                 wbRegWrite,
	output logic [`MIPS_REG_ADDR_WIDTH-1:0]      wbReg,
	output logic [`MIPS_WORD_WIDTH-1:0]          wbResult
);

	logic                        memToRegW;
	logic [`MIPS_WORD_WIDTH-1:0] execOutW;
	logic [`MIPS_WORD_WIDTH-1:0] readDataW;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wbRegWrite <= 1'b0;
			memToRegW <= 1'b0;
		end else begin
			wbRegWrite <= execMem.regWrite;
			memToRegW <= execMem.memToReg;
		end
	end

	// Data side of the memory/writeback register
	always_ff @(posedge clk) begin
		wbReg <= execMem.writeReg;
		execOutW <= execMem.execOut;
		readDataW <= memReadData;
	end

	assign wbResult = memToRegW ? readDataW : execOutW; // Load or ALU result

endmodule

`default_nettype wire

// ==== logic/mipsCore.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCfg.svh"

module mipsCore (
	input  wire logic                            clk,
	input  wire logic                            reset,
	output logic [`MIPS_WORD_WIDTH-1:0]          pc,
	input  wire logic [`MIPS_WORD_WIDTH-1:0]     instr,
	output logic                                 memWrite,
	output logic [`MIPS_WORD_WIDTH-1:0]          memAddr,
	output logic [`MIPS_WORD_WIDTH-1:0]          memWriteData,
	input  wire logic [`MIPS_WORD_WIDTH-1:0]     memReadData,
	input  wire logic [`MIPS_REG_ADDR_WIDTH-1:0] dispSel,
	output logic [`MIPS_WORD_WIDTH-1:0]          dispData
);

	mipsPkg::instrWord_t             instrD;
	mipsPkg::ctrlSig_t               ctrl;
	mipsPkg::decExec_t               decExec;
	mipsPkg::execMem_t               execMem;
	logic [`MIPS_WORD_WIDTH-1:0]     pcPlus4D;
	logic                            branchTaken;
	logic                            jumpTaken;
	logic [`MIPS_WORD_WIDTH-1:0]     branchTarget;
	logic [`MIPS_WORD_WIDTH-1:0]     jumpTarget;
	logic                            wbRegWrite;
	logic [`MIPS_REG_ADDR_WIDTH-1:0] wbReg;
	logic [`MIPS_WORD_WIDTH-1:0]     wbResult;

	controlDecoder controlDecoder_inst (
		.opcode(instrD.rType.opcode),
		.funct(instrD.rType.funct),
		.ctrl(ctrl)
	);

	fetchStage fetchStage_inst (
		.clk(clk),
		.reset(reset),
		.branchTaken(branchTaken),
		.jumpTaken(jumpTaken),
		.branchTarget(branchTarget),
		.jumpTarget(jumpTarget),
		.instr(instr),
		.pc(pc),
		.instrD(instrD),
		.pcPlus4D(pcPlus4D)
	);

	decodeStage decodeStage_inst (
		.clk(clk),
		.reset(reset),
		.instrD(instrD),
		.pcPlus4D(pcPlus4D),
		.ctrl(ctrl),
		.wbRegWrite(wbRegWrite),
		.wbReg(wbReg),
		.wbResult(wbResult),
		.dispSel(dispSel),
		.dispData(dispData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.jumpTarget(jumpTarget),
		.jumpTaken(jumpTaken),
		.decExec(decExec)
	);

	executeStage executeStage_inst (
		.clk(clk),
		.reset(reset),
		.decExec(decExec),
		.execMem(execMem)
	);

	// Memory stage is just the data RAM port
	assign memWrite = execMem.memWrite;
	assign memAddr = execMem.execOut;
	assign memWriteData = execMem.writeData;

	writebackStage writebackStage_inst (
		.clk(clk),
		.reset(reset),
		.execMem(execMem),
		.memReadData(memReadData),
		.wbRegWrite(wbRegWrite),
		.wbReg(wbReg),
		.wbResult(wbResult)
	);

endmodule

`default_nettype wire

// ==== tests/tbMemories.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCfg.svh"

// Instruction ROM, combinational read on the word address
module instrRom (
	input  wire logic [`MIPS_WORD_WIDTH-1:0] addr,
	output logic [`MIPS_WORD_WIDTH-1:0]      data
);

	logic [`MIPS_WORD_WIDTH-1:0] mem [0:1023];

	// Loaded by the testbench before reset is released
	task automatic writeWord(input logic [9:0] index, input logic [`MIPS_WORD_WIDTH-1:0] word);
		mem[index] = word;
	endtask

	assign data = mem[addr[11:2]];

endmodule

// Data RAM, combinational read and write on the rising edge
module dataRam (
	input  wire logic                        clk,
	input  wire logic                        writeEn,
	input  wire logic [`MIPS_WORD_WIDTH-1:0] addr,
	input  wire logic [`MIPS_WORD_WIDTH-1:0] writeData,
	output logic [`MIPS_WORD_WIDTH-1:0]      readData
);

	logic [`MIPS_WORD_WIDTH-1:0] mem [0:255];

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hc0de0000 ^ (i * 32'h00010101); // Differs per word
	end

	assign readData = mem[addr[9:2]];

	always @(posedge clk) begin
		if (writeEn)
			mem[addr[9:2]] <= writeData;
	end

endmodule

`default_nettype wire

// ==== tests/mipsCoreTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mipsCfg.svh"

module mipsCoreTb;

	localparam int romWords = 1024;
	localparam int modelSteps = 400;
	localparam int runTimeout = 380;
	localparam logic [5:0] aluFns [0:6] = '{`MIPS_FN_ADD, `MIPS_FN_SUB, `MIPS_FN_AND,
		`MIPS_FN_OR, `MIPS_FN_NOR, `MIPS_FN_XOR, `MIPS_FN_SLT};
	localparam logic [5:0] shiftFns [0:2] = '{`MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA};

	logic                            clk;
	logic                            reset;
	logic [`MIPS_WORD_WIDTH-1:0]     pc;
	logic [`MIPS_WORD_WIDTH-1:0]     instr;
	logic                            memWrite;
	logic [`MIPS_WORD_WIDTH-1:0]     memAddr;
	logic [`MIPS_WORD_WIDTH-1:0]     memWriteData;
	logic [`MIPS_WORD_WIDTH-1:0]     memReadData;
	logic [`MIPS_REG_ADDR_WIDTH-1:0] dispSel;
	logic [`MIPS_WORD_WIDTH-1:0]     dispData;

	logic [31:0] prog [0:romWords-1];
	logic [31:0] modelReg [0:`MIPS_NUM_REGS-1];
	logic        modelWritten [0:`MIPS_NUM_REGS-1];
	logic [31:0] modelMem [logic [31:0]];
	logic [31:0] expPc [0:modelSteps-1];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] endAddr;
	integer      seed;
	int          progLen;
	int          storeOff;
	int          storeIdx;
	int          cyc;
	int          errCount;
	int          pcChecks;
	int          storeChecks;
	int          regChecks;
	bit          timedOut;

	mipsCore mipsCore_inst (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memReadData(memReadData),
		.dispSel(dispSel),
		.dispData(dispData)
	);

	instrRom instrRom_inst (.addr(pc), .data(instr));

	dataRam dataRam_inst (
		.clk(clk),
		.writeEn(memWrite),
		.addr(memAddr),
		.writeData(memWriteData),
		.readData(memReadData)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Stores are whole words
	storeAligned: assert property (@(posedge clk) disable iff (reset)
		memWrite |-> memAddr[1:0] == 2'b00)
		else begin
			errCount++;
			$display("ERROR: memAddr %h is not word aligned", memAddr);
		end

	//------------------------------------------------------------
	// Program assembly
	//------------------------------------------------------------
	function automatic logic [31:0] rFormat(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] funct);
		return {`MIPS_OP_RTYPE, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] iFormat(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jFormat(input logic [25:0] target);
		return {`MIPS_OP_J, target};
	endfunction

	task automatic place(input logic [31:0] word);
		prog[progLen] = word;
		progLen++;
	endtask

	// Three no-ops keep each consumer four slots behind its producer
	task automatic emit(input logic [31:0] word);
		place(word);
		repeat (3) place(32'h0);
	endtask

	task automatic loadRandom(input logic [4:0] rd, input logic [31:0] value);
		emit(iFormat(`MIPS_OP_LUI, 5'd0, rd, value[31:16]));
		emit(iFormat(`MIPS_OP_ADDI, rd, rd, value[15:0]));
	endtask

	task automatic storeReg(input logic [4:0] rt);
		emit(iFormat(`MIPS_OP_SW, 5'd0, rt, storeOff[15:0]));
		storeOff += 4;
	endtask

	task automatic buildProgram();
		logic [31:0] rnd;
		for (int i = 0; i < romWords; i++)
			prog[i] = 32'h0;
		progLen = 0;
		storeOff = 0;
		loadRandom(5'd1, $random(seed));
		loadRandom(5'd2, $random(seed));
		rnd = ($random(seed) | 32'h8000_0000) & 32'hffff_7fff; // Stays negative after ADDI
		loadRandom(5'd7, rnd);
		for (int k = 0; k < 7; k++) begin
			emit(rFormat(5'd1, 5'd2, 5'd3, 5'd0, aluFns[k]));
			storeReg(5'd3);
			emit(rFormat(5'd2, 5'd1, 5'd3, 5'd0, aluFns[k]));
			storeReg(5'd3);
		end
		rnd = $random(seed);
		emit(iFormat(`MIPS_OP_ADDI, 5'd1, 5'd4, rnd[15:0]));
		storeReg(5'd4);
		emit(iFormat(`MIPS_OP_LUI, 5'd0, 5'd5, rnd[31:16]));
		storeReg(5'd5);
		for (int k = 0; k < 3; k++) begin
			rnd = $random(seed);
			emit(rFormat(5'd0, 5'd7, 5'd6, rnd[4:0] | 5'd1, shiftFns[k])); // Never by zero
			storeReg(5'd6);
			emit(rFormat(5'd0, 5'd1, 5'd6, rnd[9:5], shiftFns[k]));
			storeReg(5'd6);
		end
		emit(iFormat(`MIPS_OP_LW, 5'd0, 5'd8, 16'h0000)); // Word of the first store
		storeReg(5'd8);
		emit(iFormat(`MIPS_OP_ADDI, 5'd0, 5'd0, 16'h0055));
		storeReg(5'd0);
		emit(iFormat(`MIPS_OP_ADDI, 5'd0, 5'd9, 16'h0111));
		emit(iFormat(`MIPS_OP_ADDI, 5'd0, 5'd10, 16'h0222));
		place(iFormat(`MIPS_OP_BEQ, 5'd1, 5'd1, 16'd2)); // Taken
		place(iFormat(`MIPS_OP_ADDI, 5'd0, 5'd11, 16'h0333));
		place(iFormat(`MIPS_OP_ADDI, 5'd0, 5'd9, 16'h0999));
		emit(32'h0);
		place(iFormat(`MIPS_OP_BEQ, 5'd1, 5'd2, 16'd2)); // Not taken
		place(iFormat(`MIPS_OP_ADDI, 5'd0, 5'd12, 16'h0444));
		place(iFormat(`MIPS_OP_ADDI, 5'd0, 5'd10, 16'h0555));
		emit(32'h0);
		place(jFormat(26'(progLen + 3)));
		place(iFormat(`MIPS_OP_ADDI, 5'd0, 5'd13, 16'h0666));
		place(iFormat(`MIPS_OP_ADDI, 5'd0, 5'd9, 16'h0777));
		emit(32'h0);
		for (int r = 9; r <= 13; r++)
			storeReg(r[4:0]);
		endAddr = progLen * 4;
		place(jFormat(26'(progLen))); // Park in a loop
		place(32'h0);
	endtask

	//------------------------------------------------------------
	// Reference model stepping one instruction per fetch
	//------------------------------------------------------------
	task automatic runModel();
		logic [31:0] mpc;
		logic [31:0] npc;
		logic [31:0] nextNpc;
		logic [31:0] word;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] ea;
		logic [31:0] val;
		logic [4:0]  dst;
		logic        wr;
		mpc = 32'h0;
		npc = 32'h4;
		for (int r = 0; r < `MIPS_NUM_REGS; r++) begin
			modelReg[r] = '0;
			modelWritten[r] = (r == 0);
		end
		for (int step = 0; step < modelSteps; step++) begin
			expPc[step] = mpc;
			word = prog[mpc[11:2]];
			a = modelReg[word[25:21]];
			b = modelReg[word[20:16]];
			imm = {{16{word[15]}}, word[15:0]};
			ea = a + imm;
			nextNpc = npc + 32'h4;
			wr = 1'b0;
			dst = word[20:16];
			val = '0;
			case (word[31:26])
				`MIPS_OP_RTYPE: begin
					wr = 1'b1;
					dst = word[15:11];
					case (word[5:0])
						`MIPS_FN_ADD: val = a + b;
						`MIPS_FN_SUB: val = a - b;
						`MIPS_FN_AND: val = a & b;
						`MIPS_FN_OR:  val = a | b;
						`MIPS_FN_NOR: val = ~(a | b);
						`MIPS_FN_XOR: val = a ^ b;
						`MIPS_FN_SLT: val = {31'h0, $signed(a) < $signed(b)};
						`MIPS_FN_SLL: val = b << word[10:6];
						`MIPS_FN_SRL: val = b >> word[10:6];
						`MIPS_FN_SRA: val = $signed(b) >>> word[10:6]; // Sign fills from the left
						default:      wr = 1'b0;
					endcase
				end
				`MIPS_OP_ADDI: begin
					wr = 1'b1;
					val = ea;
				end
				`MIPS_OP_LUI: begin
					wr = 1'b1;
					val = {word[15:0], 16'h0000};
				end
				`MIPS_OP_LW: begin
					wr = 1'b1;
					val = modelMem.exists(ea) ? modelMem[ea] : 32'h0;
				end
				`MIPS_OP_SW: begin
					modelMem[ea] = b;
					expAddr.push_back(ea);
					expData.push_back(b);
				end
				`MIPS_OP_BEQ: if (a == b) nextNpc = mpc + 32'h4 + (imm << 2);
				`MIPS_OP_J: begin
					val = mpc + 32'h4;
					nextNpc = {val[31:28], word[25:0], 2'b00};
					val = '0;
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0) begin
				modelReg[dst] = val;
				modelWritten[dst] = 1'b1;
			end
			mpc = npc;
			npc = nextNpc;
		end
	endtask

	//------------------------------------------------------------
	// Checks
	//------------------------------------------------------------
	task automatic checkCycle();
		pcChecks++;
		assert (pc == expPc[cyc]) else begin
			errCount++;
			$display("ERROR: pc is %h, expected %h in cycle %0d", pc, expPc[cyc], cyc);
		end
		if (memWrite) begin
			assert (storeIdx < expAddr.size()) else begin
				errCount++;
				$display("Store to address %h that the program never makes", memAddr);
			end
			if (storeIdx < expAddr.size()) begin
				storeChecks++;
				assert (memAddr == expAddr[storeIdx]) else begin
					errCount++;
					$display("ERROR: memAddr is %h, expected %h", memAddr, expAddr[storeIdx]);
				end
				assert (memWriteData == expData[storeIdx]) else begin
					errCount++;
					$display("ERROR: memWriteData is %h, expected %h",
						memWriteData, expData[storeIdx]);
				end
				storeIdx++;
			end
		end
		cyc++;
	endtask

	// Selects each register in turn and reads it one cycle later
	task automatic checkRegisters();
		for (int r = 0; r <= `MIPS_NUM_REGS; r++) begin
			if (r > 0 && modelWritten[r-1]) begin
				regChecks++;
				assert (dispData == modelReg[r-1]) else begin
					errCount++;
					$display("ERROR: dispData for r%0d is %h, expected %h",
						r - 1, dispData, modelReg[r-1]);
				end
			end
			if (r < `MIPS_NUM_REGS)
				dispSel = r[4:0];
			@(negedge clk);
		end
	endtask

	initial begin
		seed = 32'h97d8;
		reset = 1'b1;
		dispSel = '0;
		errCount = 0;
		pcChecks = 0;
		storeChecks = 0;
		regChecks = 0;
		storeIdx = 0;
		cyc = 0;
		timedOut = 1'b0;
		buildProgram();
		for (int i = 0; i < romWords; i++)
			instrRom_inst.writeWord(10'(i), prog[i]);
		runModel();

		repeat (3) begin
			@(negedge clk);
			assert (pc == '0 && !memWrite) else begin
				errCount++;
				$display("ERROR: in reset pc is %h and memWrite is %h, expected 0 and 0",
					pc, memWrite);
			end
		end
		reset = 1'b0;

		while (!(pc == endAddr && storeIdx == expAddr.size()) && cyc < runTimeout) begin
			checkCycle();
			@(negedge clk);
		end
		if (cyc >= runTimeout) begin
			timedOut = 1'b1;
			$display("Timeout: the program did not reach its end loop with all stores done");
		end else begin
			repeat (6) begin // Drain the pipeline
				checkCycle();
				@(negedge clk);
			end
			checkRegisters();
		end

		$display("Checks: pc %0d, store %0d, register %0d; errors %0d",
			pcChecks, storeChecks, regChecks, errCount);
		if (errCount == 0 && !timedOut)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
logic/mipsPkg.sv
logic/controlDecoder.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/writebackStage.sv
logic/mipsCore.sv
tests/tbMemories.sv
tests/mipsCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the MIPS core testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module mipsCoreTb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VmipsCoreTb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
	exit 1
fi
exit 0
